/* hw/spu_isa_pkg.sv */
package spu_isa_pkg;

	localparam int NUM_REGS = 128;

	typedef logic [31:0]	instr_t;
	typedef logic [6:0]		reg_addr_t;
	typedef logic [10:0]	opcode_t;	// left-aligned in the top bits of the word
	typedef logic [7:0]		pc_t;
	typedef logic [1:0]		unit_t;

	// register fields, counted from bit 0 of the word
	localparam int RT_LSB     = 0;
	localparam int RA_LSB     = 7;
	localparam int RB_LSB     = 14;
	localparam int RT_RRR_LSB = 21;	// rrr puts the destination right below its 4-bit opcode

	// opcode prefix width per format
	localparam int OPW_RRR  = 4;
	localparam int OPW_RI18 = 7;
	localparam int OPW_RI10 = 8;
	localparam int OPW_RI16 = 9;
	localparam int OPW_RR   = 11;	// rr and ri7 use the full field

	// even pipe units
	localparam unit_t UNIT_FP   = 2'd0;
	localparam unit_t UNIT_FX2  = 2'd1;	// shift and rotate
	localparam unit_t UNIT_FX1  = 2'd3;	// simple integer

	// odd pipe units
	localparam unit_t UNIT_PERM = 2'd0;
	localparam unit_t UNIT_LS   = 2'd1;
	localparam unit_t UNIT_BR   = 2'd2;

	// even pipe opcodes
	localparam opcode_t OP_MPYA   = 11'b1100_0000000;	// rrr
	localparam opcode_t OP_FMA    = 11'b1110_0000000;	// rrr
	localparam opcode_t OP_ILA    = 11'b0100001_0000;	// ri18
	localparam opcode_t OP_AI     = 11'b00011100_000;	// ri10
	localparam opcode_t OP_A      = 11'b00011000000;
	localparam opcode_t OP_AND    = 11'b00011000001;
	localparam opcode_t OP_SHL    = 11'b00001011011;
	localparam opcode_t OP_MPY    = 11'b01111000100;
	localparam opcode_t OP_NOP    = 11'b01000000001;

	// odd pipe opcodes
	localparam opcode_t OP_LQD    = 11'b00110100_000;	// ri10
	localparam opcode_t OP_STQD   = 11'b00100100_000;	// ri10
	localparam opcode_t OP_BR     = 11'b001100100_00;	// ri16
	localparam opcode_t OP_BRZ    = 11'b001000000_00;	// ri16
	localparam opcode_t OP_LQX    = 11'b00111000100;
	localparam opcode_t OP_ROTQBY = 11'b00111011100;
	localparam opcode_t OP_LNOP   = 11'b00000000001;

endpackage

/* hw/spu_pipe_pkg.sv */
package spu_pipe_pkg;

	typedef enum logic [1:0] {
		PIPE_NONE = 2'd0,	// empty or unknown word
		PIPE_EVEN = 2'd1,
		PIPE_ODD  = 2'd2
	} pipe_t;

	typedef logic [2:0] lat_t;	// cycles a destination stays busy after issue

	// even pipe
	localparam lat_t LAT_FP   = 3'd6;
	localparam lat_t LAT_FX2  = 3'd3;
	localparam lat_t LAT_FX1  = 3'd1;

	// odd pipe
	localparam lat_t LAT_PERM = 3'd3;
	localparam lat_t LAT_LS   = 3'd5;
	localparam lat_t LAT_BR   = 3'd1;

	localparam int SB_DEPTH = 6;	// longest latency above

endpackage

/* hw/instr_decoder.sv */
module instr_decoder (
	input  spu_isa_pkg::instr_t		instr,
	output spu_pipe_pkg::pipe_t		pipe,
	output spu_isa_pkg::opcode_t	op,
	output spu_isa_pkg::unit_t		unit,
	output spu_isa_pkg::reg_addr_t	rt,
	output spu_isa_pkg::reg_addr_t	ra,
	output spu_isa_pkg::reg_addr_t	rb,
	output spu_isa_pkg::reg_addr_t	rc,
	output logic					reg_write,
	output logic					ra_used,
	output logic					rb_used,
	output logic					rc_used
);
	import spu_isa_pkg::*;
	import spu_pipe_pkg::*;

	opcode_t	op_field;
	logic [3:0]	use_flags;	// write, ra, rb, rc

	function automatic logic prefix_hit(opcode_t field, opcode_t code, int width);
		return ((field ^ code) >> ($bits(opcode_t) - width)) == '0;
	endfunction

	assign op_field = instr[$bits(instr_t)-1 -: $bits(opcode_t)];
	assign ra = instr[RA_LSB +: $bits(reg_addr_t)];
	assign rb = instr[RB_LSB +: $bits(reg_addr_t)];
	assign rc = instr[RT_LSB +: $bits(reg_addr_t)];	// rrr third source, store/branch value
	assign {reg_write, ra_used, rb_used, rc_used} = use_flags;

	// even table first, then odd; the zero word matches no entry
	always_comb begin
		pipe = PIPE_NONE;
		op = '0;
		unit = '0;
		rt = instr[RT_LSB +: $bits(reg_addr_t)];
		use_flags = 4'b0000;
		if (prefix_hit(op_field, OP_MPYA, OPW_RRR) || prefix_hit(op_field, OP_FMA, OPW_RRR)) begin
			pipe = PIPE_EVEN;
			op = prefix_hit(op_field, OP_MPYA, OPW_RRR) ? OP_MPYA : OP_FMA;
			unit = UNIT_FP;
			rt = instr[RT_RRR_LSB +: $bits(reg_addr_t)];
			use_flags = 4'b1111;
		end else if (prefix_hit(op_field, OP_ILA, OPW_RI18)) begin
			pipe = PIPE_EVEN;
			op = OP_ILA;
			unit = UNIT_FX1;
			use_flags = 4'b1000;	// immediate only
		end else if (prefix_hit(op_field, OP_AI, OPW_RI10)) begin
			pipe = PIPE_EVEN;
			op = OP_AI;
			unit = UNIT_FX1;
			use_flags = 4'b1100;
		end else if (op_field == OP_A || op_field == OP_AND) begin
			pipe = PIPE_EVEN;
			op = op_field;
			unit = UNIT_FX1;
			use_flags = 4'b1110;
		end else if (op_field == OP_SHL) begin
			pipe = PIPE_EVEN;
			op = OP_SHL;
			unit = UNIT_FX2;
			use_flags = 4'b1110;
		end else if (op_field == OP_MPY) begin
			pipe = PIPE_EVEN;
			op = OP_MPY;
			unit = UNIT_FP;
			use_flags = 4'b1110;
		end else if (op_field == OP_NOP) begin
			pipe = PIPE_EVEN;
			op = OP_NOP;
			unit = UNIT_FP;
		end else if (prefix_hit(op_field, OP_LQD, OPW_RI10)) begin
			pipe = PIPE_ODD;
			op = OP_LQD;
			unit = UNIT_LS;
			use_flags = 4'b1100;
		end else if (prefix_hit(op_field, OP_STQD, OPW_RI10)) begin
			pipe = PIPE_ODD;
			op = OP_STQD;
			unit = UNIT_LS;
			use_flags = 4'b0101;	// base in ra, data in rt field
		end else if (prefix_hit(op_field, OP_BR, OPW_RI16)) begin
			pipe = PIPE_ODD;
			op = OP_BR;
			unit = UNIT_BR;
		end else if (prefix_hit(op_field, OP_BRZ, OPW_RI16)) begin
			pipe = PIPE_ODD;
			op = OP_BRZ;
			unit = UNIT_BR;
			use_flags = 4'b0001;	// tested value
		end else if (op_field == OP_LQX) begin
			pipe = PIPE_ODD;
			op = OP_LQX;
			unit = UNIT_LS;
			use_flags = 4'b1110;
		end else if (prefix_hit(op_field, OP_ROTQBY, OPW_RR)) begin
			pipe = PIPE_ODD;
			op = OP_ROTQBY;
			unit = UNIT_PERM;
			use_flags = 4'b1110;
		end else if (op_field == OP_LNOP) begin
			pipe = PIPE_ODD;
			op = OP_LNOP;
			unit = UNIT_PERM;
		end
		if (pipe == PIPE_NONE) begin
			rt = '0;
		end
	end

endmodule

/* hw/hazard_check.sv */
module hazard_check (
	input  spu_pipe_pkg::pipe_t				pipe_first,
	input  spu_pipe_pkg::pipe_t				pipe_second,
	input  spu_isa_pkg::reg_addr_t			rt_first,
	input  spu_isa_pkg::reg_addr_t			ra_first,
	input  spu_isa_pkg::reg_addr_t			rb_first,
	input  spu_isa_pkg::reg_addr_t			rc_first,
	input  logic							reg_write_first,
	input  logic							ra_used_first,
	input  logic							rb_used_first,
	input  logic							rc_used_first,
	input  spu_isa_pkg::reg_addr_t			rt_second,
	input  spu_isa_pkg::reg_addr_t			ra_second,
	input  spu_isa_pkg::reg_addr_t			rb_second,
	input  spu_isa_pkg::reg_addr_t			rc_second,
	input  logic							reg_write_second,
	input  logic							ra_used_second,
	input  logic							rb_used_second,
	input  logic							rc_used_second,
	input  logic [spu_isa_pkg::NUM_REGS-1:0]	busy,
	output logic							stall_first,
	output logic							stall_second
);
	import spu_pipe_pkg::*;

	logic	busy_second;	// in-flight raw
	logic	same_pipe;		// structural
	logic	same_dest;		// waw inside the pair
	logic	raw_pair;		// second reads what first writes

	assign stall_first = (ra_used_first && busy[ra_first])
		|| (rb_used_first && busy[rb_first])
		|| (rc_used_first && busy[rc_first]);

	assign busy_second = (ra_used_second && busy[ra_second])
		|| (rb_used_second && busy[rb_second])
		|| (rc_used_second && busy[rc_second]);

	assign same_pipe = (pipe_second != PIPE_NONE) && (pipe_second == pipe_first);
	assign same_dest = reg_write_first && reg_write_second && (rt_first == rt_second);
	assign raw_pair = reg_write_first
		&& ((ra_used_second && (ra_second == rt_first))
		|| (rb_used_second && (rb_second == rt_first))
		|| (rc_used_second && (rc_second == rt_first)));

	// a stalled first instruction holds the whole pair back
	assign stall_second = stall_first || same_pipe || same_dest || raw_pair || busy_second;

endmodule

/* hw/dest_scoreboard.sv */
module dest_scoreboard (
	input  logic								clk,
	input  logic								reset,
	input  spu_isa_pkg::reg_addr_t				issue_even_rt,
	input  spu_isa_pkg::reg_addr_t				issue_odd_rt,
	input  logic								issue_even_write,
	input  logic								issue_odd_write,
	input  spu_isa_pkg::unit_t					issue_even_unit,
	input  spu_isa_pkg::unit_t					issue_odd_unit,
	output logic [spu_isa_pkg::NUM_REGS-1:0]	busy
);
	import spu_isa_pkg::*;
	import spu_pipe_pkg::*;

	// [pipe][stage], pipe 0 even, 1 odd; stage 0 is the slot issued at the last edge
	reg_addr_t	st_rt		[2][SB_DEPTH];
	logic		st_wr		[2][SB_DEPTH];
	lat_t		st_lat		[2][SB_DEPTH];
	reg_addr_t	hist_rt		[2][1:SB_DEPTH-1];
	logic		hist_wr		[2][1:SB_DEPTH-1];
	lat_t		hist_lat	[2][1:SB_DEPTH-1];

	function automatic lat_t unit_latency(logic odd, unit_t unit);
		if (odd) begin
			case (unit)
				UNIT_PERM: return LAT_PERM;
				UNIT_LS:   return LAT_LS;
				UNIT_BR:   return LAT_BR;
				default:   return '0;
			endcase
		end
		case (unit)
			UNIT_FP:  return LAT_FP;
			UNIT_FX2: return LAT_FX2;
			UNIT_FX1: return LAT_FX1;
			default:  return '0;	// unused even code
		endcase
	endfunction

	always_comb begin
		st_rt[0][0] = issue_even_rt;
		st_wr[0][0] = issue_even_write;
		st_lat[0][0] = unit_latency(1'b0, issue_even_unit);
		st_rt[1][0] = issue_odd_rt;
		st_wr[1][0] = issue_odd_write;
		st_lat[1][0] = unit_latency(1'b1, issue_odd_unit);
		for (int p = 0; p < 2; p++) begin
			for (int k = 1; k < SB_DEPTH; k++) begin
				st_rt[p][k] = hist_rt[p][k];
				st_wr[p][k] = hist_wr[p][k];
				st_lat[p][k] = hist_lat[p][k];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			for (int k = 1; k < SB_DEPTH; k++) begin
				hist_rt[p][k] <= st_rt[p][k-1];
				hist_lat[p][k] <= st_lat[p][k-1];
				if (reset) begin
					hist_wr[p][k] <= 1'b0;
				end else begin
					hist_wr[p][k] <= st_wr[p][k-1];
				end
			end
		end
	end

	always_comb begin
		busy = '0;
		for (int p = 0; p < 2; p++) begin
			for (int k = 0; k < SB_DEPTH; k++) begin
				if (st_wr[p][k] && (k < st_lat[p][k])) begin
					busy[st_rt[p][k]] = 1'b1;	// still k cycles short of its latency
				end
			end
		end
	end

	// the waw check upstream keeps the two pipes off the same register
	dual_write: assert property (@(posedge clk) disable iff (reset)
		!(issue_even_write && issue_odd_write && (issue_even_rt == issue_odd_rt)));

endmodule

/* hw/issue_control.sv */
module issue_control (
	input  logic					clk,
	input  logic					reset,
	input  spu_isa_pkg::instr_t		instr_first,
	input  spu_isa_pkg::instr_t		instr_second,
	input  spu_isa_pkg::pc_t		pc,
	input  logic					branch_taken,
	input  spu_isa_pkg::pc_t		branch_pc,
	input  spu_pipe_pkg::pipe_t		pipe_first,
	input  spu_isa_pkg::opcode_t	op_first,
	input  spu_isa_pkg::unit_t		unit_first,
	input  spu_isa_pkg::reg_addr_t	rt_first,
	input  logic					reg_write_first,
	input  spu_pipe_pkg::pipe_t		pipe_second,
	input  spu_isa_pkg::opcode_t	op_second,
	input  spu_isa_pkg::unit_t		unit_second,
	input  spu_isa_pkg::reg_addr_t	rt_second,
	input  logic					reg_write_second,
	input  logic					stall_first,
	input  logic					stall_second,
	output spu_isa_pkg::instr_t		sel_first,
	output spu_isa_pkg::instr_t		sel_second,
	output spu_isa_pkg::instr_t		even_instr,
	output spu_isa_pkg::opcode_t	even_op,
	output spu_isa_pkg::unit_t		even_unit,
	output spu_isa_pkg::reg_addr_t	even_rt,
	output logic					even_write,
	output spu_isa_pkg::instr_t		odd_instr,
	output spu_isa_pkg::opcode_t	odd_op,
	output spu_isa_pkg::unit_t		odd_unit,
	output spu_isa_pkg::reg_addr_t	odd_rt,
	output logic					odd_write,
	output logic					first_odd,
	output logic					stall,
	output spu_isa_pkg::pc_t		stall_pc
);
	import spu_isa_pkg::*;
	import spu_pipe_pkg::*;

	instr_t	q_first, q_second;	// held pair
	pc_t	sel_pc;
	logic	go_first, go_second;

	assign sel_first = stall ? q_first : instr_first;
	assign sel_second = stall ? q_second : instr_second;
	assign sel_pc = stall ? stall_pc : pc;	// queued pair keeps its own address
	assign go_first = !branch_taken && !stall_first;
	assign go_second = !branch_taken && !stall_second;

	always_ff @(posedge clk) begin
		if (reset) begin
			{even_instr, even_op, even_unit, even_rt, even_write} <= '0;
			{odd_instr, odd_op, odd_unit, odd_rt, odd_write} <= '0;
			first_odd <= 1'b0;
			stall <= 1'b0;
			stall_pc <= '0;
		end else begin
			if (go_first && (pipe_first == PIPE_EVEN)) begin
				{even_instr, even_op, even_unit, even_rt, even_write} <=
					{sel_first, op_first, unit_first, rt_first, reg_write_first};
			end else if (go_second && (pipe_second == PIPE_EVEN)) begin
				{even_instr, even_op, even_unit, even_rt, even_write} <=
					{sel_second, op_second, unit_second, rt_second, reg_write_second};
			end else begin
				{even_instr, even_op, even_unit, even_rt, even_write} <= '0;
			end
			if (go_first && (pipe_first == PIPE_ODD)) begin
				{odd_instr, odd_op, odd_unit, odd_rt, odd_write} <=
					{sel_first, op_first, unit_first, rt_first, reg_write_first};
			end else if (go_second && (pipe_second == PIPE_ODD)) begin
				{odd_instr, odd_op, odd_unit, odd_rt, odd_write} <=
					{sel_second, op_second, unit_second, rt_second, reg_write_second};
			end else begin
				{odd_instr, odd_op, odd_unit, odd_rt, odd_write} <= '0;
			end
			first_odd <= go_first && (pipe_first == PIPE_ODD);
			if (branch_taken) begin
				stall <= 1'b1;
				stall_pc <= branch_pc + pc_t'(2);	// refetch past the branch pair
			end else if (stall_first || stall_second) begin
				stall <= 1'b1;
				stall_pc <= sel_pc;
			end else begin
				stall <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (branch_taken) begin
			q_first <= '0;
			q_second <= '0;
		end else if (stall_first) begin
			q_first <= sel_first;	// retry the whole pair
			q_second <= sel_second;
		end else if (stall_second) begin
			q_first <= '0;
			q_second <= sel_second;
		end
	end

	// second cycle covers the drained queue
	flush_empty: assert property (@(posedge clk) disable iff (reset)
		branch_taken |=> !(even_write || odd_write) ##1 !(even_write || odd_write));

endmodule

/* hw/dual_issue_decode.sv */
module dual_issue_decode (
	input  logic					clk,
	input  logic					reset,
	input  spu_isa_pkg::instr_t		instr_first,
	input  spu_isa_pkg::instr_t		instr_second,
	input  spu_isa_pkg::pc_t		pc,
	input  spu_isa_pkg::pc_t		branch_pc,
	input  logic					branch_taken,
	output spu_isa_pkg::instr_t		even_instr,
	output spu_isa_pkg::opcode_t	even_op,
	output spu_isa_pkg::unit_t		even_unit,
	output spu_isa_pkg::reg_addr_t	even_rt,
	output logic					even_write,
	output spu_isa_pkg::instr_t		odd_instr,
	output spu_isa_pkg::opcode_t	odd_op,
	output spu_isa_pkg::unit_t		odd_unit,
	output spu_isa_pkg::reg_addr_t	odd_rt,
	output logic					odd_write,
	output logic					first_odd,
	output logic					stall,
	output spu_isa_pkg::pc_t		stall_pc
);
	import spu_isa_pkg::*;
	import spu_pipe_pkg::*;

	instr_t					sel_first, sel_second;
	pipe_t					pipe_first, pipe_second;
	opcode_t				op_first, op_second;
	unit_t					unit_first, unit_second;
	reg_addr_t				rt_first, rt_second;
	reg_addr_t				ra_first, ra_second;
	reg_addr_t				rb_first, rb_second;
	reg_addr_t				rc_first, rc_second;
	logic					reg_write_first, reg_write_second;
	logic					ra_used_first, ra_used_second;
	logic					rb_used_first, rb_used_second;
	logic					rc_used_first, rc_used_second;
	logic					stall_first, stall_second;
	logic [NUM_REGS-1:0]	busy;	// in-flight destinations

	instr_decoder u_dec_first (
		.instr(sel_first), .pipe(pipe_first), .op(op_first), .unit(unit_first),
		.rt(rt_first), .ra(ra_first), .rb(rb_first), .rc(rc_first),
		.reg_write(reg_write_first), .ra_used(ra_used_first),
		.rb_used(rb_used_first), .rc_used(rc_used_first)
	);

	instr_decoder u_dec_second (
		.instr(sel_second), .pipe(pipe_second), .op(op_second), .unit(unit_second),
		.rt(rt_second), .ra(ra_second), .rb(rb_second), .rc(rc_second),
		.reg_write(reg_write_second), .ra_used(ra_used_second),
		.rb_used(rb_used_second), .rc_used(rc_used_second)
	);

	hazard_check u_hazard_check (
		.pipe_first(pipe_first), .pipe_second(pipe_second),
		.rt_first(rt_first), .ra_first(ra_first), .rb_first(rb_first), .rc_first(rc_first),
		.reg_write_first(reg_write_first), .ra_used_first(ra_used_first),
		.rb_used_first(rb_used_first), .rc_used_first(rc_used_first),
		.rt_second(rt_second), .ra_second(ra_second), .rb_second(rb_second),
		.rc_second(rc_second), .reg_write_second(reg_write_second),
		.ra_used_second(ra_used_second), .rb_used_second(rb_used_second),
		.rc_used_second(rc_used_second), .busy(busy),
		.stall_first(stall_first), .stall_second(stall_second)
	);

	// the issue slots double as the scoreboard's write port
	dest_scoreboard u_dest_scoreboard (
		.clk(clk), .reset(reset),
		.issue_even_rt(even_rt), .issue_odd_rt(odd_rt),
		.issue_even_write(even_write), .issue_odd_write(odd_write),
		.issue_even_unit(even_unit), .issue_odd_unit(odd_unit),
		.busy(busy)
	);

	issue_control u_issue_control (
		.clk(clk), .reset(reset),
		.instr_first(instr_first), .instr_second(instr_second), .pc(pc),
		.branch_taken(branch_taken), .branch_pc(branch_pc),
		.pipe_first(pipe_first), .op_first(op_first), .unit_first(unit_first),
		.rt_first(rt_first), .reg_write_first(reg_write_first),
		.pipe_second(pipe_second), .op_second(op_second), .unit_second(unit_second),
		.rt_second(rt_second), .reg_write_second(reg_write_second),
		.stall_first(stall_first), .stall_second(stall_second),
		.sel_first(sel_first), .sel_second(sel_second),
		.even_instr(even_instr), .even_op(even_op), .even_unit(even_unit),
		.even_rt(even_rt), .even_write(even_write),
		.odd_instr(odd_instr), .odd_op(odd_op), .odd_unit(odd_unit),
		.odd_rt(odd_rt), .odd_write(odd_write),
		.first_odd(first_odd), .stall(stall), .stall_pc(stall_pc)
	);

endmodule

/* testbench/tb_dual_issue_decode.sv */
module tb_dual_issue_decode;
	import spu_isa_pkg::*;
	import spu_pipe_pkg::*;

	localparam int TEST_CYCLES = 60;	// rough length of all tests together
	localparam int MAX_CYCLES = 3 * TEST_CYCLES + 20;

	logic		clk;
	logic		reset;
	instr_t		instr_first;
	instr_t		instr_second;
	pc_t		pc;
	pc_t		branch_pc;
	logic		branch_taken;
	instr_t		even_instr;
	opcode_t	even_op;
	unit_t		even_unit;
	reg_addr_t	even_rt;
	logic		even_write;
	instr_t		odd_instr;
	opcode_t	odd_op;
	unit_t		odd_unit;
	reg_addr_t	odd_rt;
	logic		odd_write;
	logic		first_odd;
	logic		stall;
	pc_t		stall_pc;

	int			cycle_count = 0;
	int			error_count = 0;
	int			check_count = 0;
	int			tests_run = 0;

	dual_issue_decode u_dual_issue_decode (
		.clk(clk), .reset(reset),
		.instr_first(instr_first), .instr_second(instr_second), .pc(pc),
		.branch_pc(branch_pc), .branch_taken(branch_taken),
		.even_instr(even_instr), .even_op(even_op), .even_unit(even_unit),
		.even_rt(even_rt), .even_write(even_write),
		.odd_instr(odd_instr), .odd_op(odd_op), .odd_unit(odd_unit),
		.odd_rt(odd_rt), .odd_write(odd_write),
		.first_odd(first_odd), .stall(stall), .stall_pc(stall_pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycle_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// rr and ri7 layout: opcode, rb, ra, rt
	function automatic instr_t rr_word(opcode_t op, reg_addr_t rt, reg_addr_t ra, reg_addr_t rb);
		return {op, rb, ra, rt};
	endfunction

	function automatic instr_t ri10_word(opcode_t op, reg_addr_t rt, reg_addr_t ra);
		return {op, 7'd0, ra, rt};	// zero immediate
	endfunction

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	task automatic drive_pair(input instr_t first, input instr_t second, input pc_t addr);
		instr_first = first;
		instr_second = second;
		pc = addr;
	endtask

	// outputs are stable at the falling edge, where the next inputs go in
	task automatic step_edge();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic even_slot_is(input instr_t word, input opcode_t op, input unit_t unit,
			input reg_addr_t rt);
		compare("even_write", even_write, 1'b1);
		compare("even_instr", even_instr, word);
		compare("even_op", even_op, op);
		compare("even_unit", even_unit, unit);
		compare("even_rt", even_rt, rt);
	endtask

	task automatic odd_slot_is(input instr_t word, input opcode_t op, input unit_t unit,
			input reg_addr_t rt);
		compare("odd_write", odd_write, 1'b1);
		compare("odd_instr", odd_instr, word);
		compare("odd_op", odd_op, op);
		compare("odd_unit", odd_unit, unit);
		compare("odd_rt", odd_rt, rt);
	endtask

	// feeds empty words until stall drops, counting edges
	task automatic await_release(input int limit, output int edges);
		edges = 0;
		do begin
			drive_pair('0, '0, '0);
			step_edge();
			edges++;
		end while (stall && edges < limit);
		if (stall) begin
			error_count++;
			$display("stall stayed high for %0d cycles, the queued instruction never issued",
				limit);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic reset_state();
		int errors_before;
		errors_before = error_count;
		compare("stall", stall, 1'b0);
		compare("stall_pc", stall_pc, 8'h00);
		compare("even_write", even_write, 1'b0);
		compare("odd_write", odd_write, 1'b0);
		compare("even_instr", even_instr, 32'h0);
		compare("odd_instr", odd_instr, 32'h0);
		compare("first_odd", first_odd, 1'b0);
		report_test("reset", errors_before);
	endtask

	task automatic routing();
		int errors_before;
		instr_t lqd, add, shl, rot;
		errors_before = error_count;
		lqd = ri10_word(OP_LQD, 10, 1);
		add = rr_word(OP_A, 11, 2, 3);
		drive_pair(lqd, add, 8'h04);
		step_edge();
		odd_slot_is(lqd, OP_LQD, UNIT_LS, 10);
		even_slot_is(add, OP_A, UNIT_FX1, 11);
		compare("first_odd", first_odd, 1'b1);
		compare("stall", stall, 1'b0);
		shl = rr_word(OP_SHL, 12, 4, 5);
		rot = rr_word(OP_ROTQBY, 13, 6, 7);
		drive_pair(shl, rot, 8'h06);
		step_edge();
		even_slot_is(shl, OP_SHL, UNIT_FX2, 12);
		odd_slot_is(rot, OP_ROTQBY, UNIT_PERM, 13);
		compare("first_odd", first_odd, 1'b0);
		compare("stall", stall, 1'b0);
		report_test("routing", errors_before);
	endtask

	task automatic structural_hazard();
		int errors_before;
		instr_t add, band;
		errors_before = error_count;
		add = rr_word(OP_A, 20, 21, 22);
		band = rr_word(OP_AND, 23, 24, 25);
		drive_pair(add, band, 8'h10);
		step_edge();
		even_slot_is(add, OP_A, UNIT_FX1, 20);
		compare("odd_write", odd_write, 1'b0);
		compare("stall", stall, 1'b1);
		compare("stall_pc", stall_pc, 8'h10);
		drive_pair(add, band, 8'h10);	// refetch, must be ignored
		step_edge();
		even_slot_is(band, OP_AND, UNIT_FX1, 23);
		compare("odd_write", odd_write, 1'b0);
		compare("first_odd", first_odd, 1'b0);
		compare("stall", stall, 1'b0);
		report_test("structural hazard", errors_before);
	endtask

	task automatic pair_dependence();
		int errors_before;
		int edges;
		instr_t add, lqx, lqd;
		errors_before = error_count;
		// raw: r30 stays busy for LAT_FX1 cycles after the writer's edge
		add = rr_word(OP_A, 30, 31, 32);
		lqx = rr_word(OP_LQX, 33, 30, 34);
		drive_pair(add, lqx, 8'h14);
		step_edge();
		even_slot_is(add, OP_A, UNIT_FX1, 30);
		compare("odd_write", odd_write, 1'b0);
		compare("stall", stall, 1'b1);
		compare("stall_pc", stall_pc, 8'h14);
		await_release(4 * SB_DEPTH, edges);
		compare("raw release edges", edges, int'(LAT_FX1) + 1);
		odd_slot_is(lqx, OP_LQX, UNIT_LS, 33);
		compare("even_write", even_write, 1'b0);
		// waw across pipes
		add = rr_word(OP_A, 40, 41, 42);
		lqd = ri10_word(OP_LQD, 40, 43);
		drive_pair(add, lqd, 8'h18);
		step_edge();
		even_slot_is(add, OP_A, UNIT_FX1, 40);
		compare("odd_write", odd_write, 1'b0);
		compare("stall", stall, 1'b1);
		compare("stall_pc", stall_pc, 8'h18);
		drive_pair('0, '0, '0);
		step_edge();
		odd_slot_is(lqd, OP_LQD, UNIT_LS, 40);
		compare("stall", stall, 1'b0);
		report_test("in-pair dependence", errors_before);
	endtask

	task automatic inflight_raw();
		int errors_before;
		int edges;
		instr_t add, mpy, reader_even, reader_odd;
		errors_before = error_count;
		add = rr_word(OP_A, 5, 50, 51);
		mpy = rr_word(OP_MPY, 9, 52, 53);
		reader_even = rr_word(OP_A, 58, 5, 59);	// r5 free again by now
		reader_odd = rr_word(OP_LQX, 54, 9, 55);
		drive_pair(add, '0, 8'h30);
		step_edge();
		even_slot_is(add, OP_A, UNIT_FX1, 5);
		drive_pair(mpy, '0, 8'h32);
		step_edge();
		even_slot_is(mpy, OP_MPY, UNIT_FP, 9);
		compare("stall", stall, 1'b0);
		drive_pair(reader_even, reader_odd, 8'h34);
		step_edge();
		even_slot_is(reader_even, OP_A, UNIT_FX1, 58);
		compare("odd_write", odd_write, 1'b0);
		compare("first_odd", first_odd, 1'b0);
		compare("stall", stall, 1'b1);
		compare("stall_pc", stall_pc, 8'h34);
		await_release(4 * SB_DEPTH, edges);
		// busy for LAT_FP cycles, issue in the one after
		compare("reader issue edge", edges + 1, int'(LAT_FP) + 1);
		odd_slot_is(reader_odd, OP_LQX, UNIT_LS, 54);
		report_test("in-flight raw", errors_before);
	endtask

	task automatic branch_flush();
		int errors_before;
		instr_t add, shl;
		pc_t target;
		errors_before = error_count;
		add = rr_word(OP_A, 60, 61, 62);
		shl = rr_word(OP_SHL, 63, 64, 65);
		target = 8'h40;
		drive_pair(add, shl, 8'h20);
		step_edge();
		even_slot_is(add, OP_A, UNIT_FX1, 60);
		compare("stall", stall, 1'b1);
		drive_pair('0, '0, '0);
		branch_taken = 1'b1;
		branch_pc = target;
		step_edge();
		branch_taken = 1'b0;
		compare("even_write", even_write, 1'b0);
		compare("odd_write", odd_write, 1'b0);
		compare("stall", stall, 1'b1);
		compare("stall_pc", stall_pc, target + pc_t'(2));
		repeat (2) begin
			step_edge();
			compare("even_write", even_write, 1'b0);	// shl was dropped with the queue
			compare("odd_write", odd_write, 1'b0);
			compare("stall", stall, 1'b0);
		end
		report_test("branch flush", errors_before);
	endtask

	task automatic unknown_words();
		int errors_before;
		instr_t bad, add;
		errors_before = error_count;
		bad = 32'hffff_ffff;	// matches neither table
		add = rr_word(OP_A, 70, 71, 72);
		drive_pair(bad, '0, 8'h50);
		step_edge();
		compare("even_write", even_write, 1'b0);
		compare("odd_write", odd_write, 1'b0);
		compare("even_instr", even_instr, 32'h0);
		compare("odd_instr", odd_instr, 32'h0);
		compare("first_odd", first_odd, 1'b0);
		compare("stall", stall, 1'b0);
		drive_pair('0, '0, 8'h52);
		step_edge();
		compare("even_write", even_write, 1'b0);
		compare("odd_write", odd_write, 1'b0);
		compare("stall", stall, 1'b0);
		drive_pair(bad, add, 8'h54);
		step_edge();
		even_slot_is(add, OP_A, UNIT_FX1, 70);
		compare("odd_write", odd_write, 1'b0);
		compare("first_odd", first_odd, 1'b0);
		compare("stall", stall, 1'b0);
		report_test("unknown and empty words", errors_before);
	endtask

	initial begin
		reset = 1'b1;
		branch_taken = 1'b0;
		branch_pc = '0;
		drive_pair('0, '0, '0);
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		reset_state();
		routing();
		structural_hazard();
		pair_dependence();
		inflight_raw();
		branch_flush();
		unknown_words();
		$display("tests %0d, checks %0d, errors %0d, cycles %0d",
			tests_run, check_count, error_count, cycle_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* project.f */
hw/spu_isa_pkg.sv
hw/spu_pipe_pkg.sv
hw/instr_decoder.sv
hw/hazard_check.sv
hw/dest_scoreboard.sv
hw/issue_control.sv
hw/dual_issue_decode.sv
testbench/tb_dual_issue_decode.sv

/* Bender.yml */
package:
  name: dual_issue_decode

sources:
  - hw/spu_isa_pkg.sv
  - hw/spu_pipe_pkg.sv
  - hw/instr_decoder.sv
  - hw/hazard_check.sv
  - hw/dest_scoreboard.sv
  - hw/issue_control.sv
  - hw/dual_issue_decode.sv
  - target: test
    files:
      - testbench/tb_dual_issue_decode.sv
